/* logic/codec_config_settings.svh */
`ifndef CODEC_CONFIG_SETTINGS_SVH
`define CODEC_CONFIG_SETTINGS_SVH

// System clocks per quarter of an I2C bit.
`define CODEC_TICK_DIV 4

// Entries in the codec initialisation table.
`define CODEC_TABLE_LEN 8

// APB byte addresses.
`define CODEC_ADDR_CMD    4'h0
`define CODEC_ADDR_FRAME  4'h4
`define CODEC_ADDR_STATUS 4'h8

`endif

/* logic/codec_config_pkg.sv */
package codec_config_pkg;

	// Opcodes for the command register.
	typedef enum logic [1:0] {
		CMD_NONE      = 2'd0,
		CMD_SINGLE    = 2'd1,
		CMD_RUN_TABLE = 2'd2
	} cmd_e;

	typedef enum logic [2:0] {
		IDLE,
		SEND,
		WAIT_FRAME,
		NEXT_ENTRY,
		FINISH
	} ctrl_state_e;

	// Sent on the bus from dev_addr down, MSB first.
	typedef struct packed {
		logic [7:0] dev_addr;
		logic [7:0] reg_addr;
		logic [7:0] data;
	} frame_t;

	typedef struct packed {
		logic       busy;
		logic       ack_error;
		logic [7:0] frames_sent;
	} status_t;

endpackage

/* logic/i2c_bit_clock.sv */
`include "codec_config_settings.svh"

module i2c_bit_clock (
	input  logic CLOCK,
	input  logic RESET,
	input  logic tick_enable,
	output logic tick
);

	localparam int DIV = `CODEC_TICK_DIV;
	localparam int CW = $clog2(DIV);

	logic [CW-1:0] count;

	// Restart on every enable so each frame starts with the same phase.
	always_ff @(posedge CLOCK) begin
		if (RESET) begin
			count <= '0;
			tick <= 1'b0;
		end else if (!tick_enable) begin
			count <= '0;
			tick <= 1'b0;
		end else if (count == CW'(DIV - 1)) begin
			count <= '0;
			tick <= 1'b1;
		end else begin
			count <= count + CW'(1);
			tick <= 1'b0;
		end
	end

	assert property (@(posedge CLOCK) disable iff (RESET) tick |=> !tick);

endmodule

/* logic/i2c_frame_writer.sv */
module i2c_frame_writer (
	input  logic                     CLOCK,
	input  logic                     RESET,
	input  logic                     frame_go,
	input  codec_config_pkg::frame_t frame,
	input  logic                     tick,
	output logic                     tick_enable,
	output logic                     scl,
	output logic                     sda_oe,
	input  logic                     sda_in,
	output logic                     frame_done,
	output logic                     ack_error
);

	// Slot 0 is the start, slots 1 to 27 carry bits, slot 28 is the stop.
	localparam logic [4:0] START_SLOT = 5'd0;
	localparam logic [4:0] STOP_SLOT = 5'd28;

	logic        active;
	logic [1:0]  phase;
	logic [4:0]  slot;
	logic [23:0] shift;
	logic        ack_slot;
	logic        framing;

	assign tick_enable = active;
	assign ack_slot = (slot == 5'd9) || (slot == 5'd18) || (slot == 5'd27);
	assign framing = (slot == START_SLOT) || (slot == STOP_SLOT);

	always_ff @(posedge CLOCK) begin
		if (frame_go && !active) begin
			shift <= frame;
		end else if (active && tick && phase == 2'd0 && !framing && !ack_slot) begin
			shift <= {shift[22:0], 1'b0};
		end
	end

	// Four ticks per slot: set SDA, raise SCL, sample, lower SCL.
	always_ff @(posedge CLOCK) begin
		if (RESET) begin
			active <= 1'b0;
			phase <= 2'd0;
			slot <= START_SLOT;
			scl <= 1'b1;
			sda_oe <= 1'b0;
			frame_done <= 1'b0;
			ack_error <= 1'b0;
		end else begin
			frame_done <= 1'b0;
			if (frame_go && !active) begin
				active <= 1'b1;
				phase <= 2'd0;
				slot <= START_SLOT;
				ack_error <= 1'b0;
			end else if (active && tick) begin
				phase <= phase + 2'd1;
				case (phase)
				2'd0: begin
					if (framing) begin
						sda_oe <= 1'b1;
					end else if (ack_slot) begin
						sda_oe <= 1'b0;
					end else begin
						sda_oe <= !shift[23];
					end
				end
				2'd1: begin
					if (slot != START_SLOT) begin
						scl <= 1'b1;
					end
				end
				2'd2: begin
					if (slot == START_SLOT) begin
						scl <= 1'b0;
					end else if (slot == STOP_SLOT) begin
						sda_oe <= 1'b0;
					end else if (ack_slot) begin
						ack_error <= ack_error | sda_in;
					end
				end
				default: begin
					if (slot == STOP_SLOT) begin
						active <= 1'b0;
						slot <= START_SLOT;
						frame_done <= 1'b1;
					end else begin
						scl <= 1'b0;
						slot <= slot + 5'd1;
					end
				end
				endcase
			end
		end
	end

	// The sequencer must wait for frame_done before the next go.
	assert property (@(posedge CLOCK) disable iff (RESET) frame_go |-> !active);

	// Data only moves under a low SCL; start and stop are the exceptions.
	assert property (@(posedge CLOCK) disable iff (RESET)
		(sda_oe != $past(sda_oe)) |-> (!$past(scl) || $past(framing)));

endmodule

/* logic/config_table.sv */
module config_table (
	input  logic                     CLOCK,
	input  logic [2:0]               table_index,
	output codec_config_pkg::frame_t table_entry
);

	logic [7:0] data_byte;

	// Codec power-up values.
	always_comb begin
		case (table_index)
		3'd0: data_byte = 8'h97;
		3'd1: data_byte = 8'h97;
		3'd2: data_byte = 8'h79;
		3'd3: data_byte = 8'h79;
		3'd4: data_byte = 8'h10;
		3'd5: data_byte = 8'h00;
		3'd6: data_byte = 8'h42;
		default: data_byte = 8'h01;
		endcase
	end

	// Register byte is twice the index.
	always_ff @(posedge CLOCK) begin
		table_entry.dev_addr <= 8'h34;
		table_entry.reg_addr <= {4'b0000, table_index, 1'b0};
		table_entry.data <= data_byte;
	end

endmodule

/* logic/apb_config_regs.sv */
`include "codec_config_settings.svh"

module apb_config_regs (
	input  logic                      CLOCK,
	input  logic                      RESET,
	input  logic                      psel,
	input  logic                      penable,
	input  logic                      pwrite,
	input  logic [3:0]                paddr,
	input  logic [31:0]               pwdata,
	output logic [31:0]               prdata,
	output logic                      pready,
	output logic                      pslverr,
	input  codec_config_pkg::status_t status,
	output logic                      cmd_valid,
	output codec_config_pkg::cmd_e    cmd,
	output codec_config_pkg::frame_t  frame
);

	logic                   write_access;
	logic                   cmd_write;
	codec_config_pkg::cmd_e new_cmd;

	assign write_access = psel && penable && pwrite;
	assign cmd_write = write_access && (paddr == `CODEC_ADDR_CMD);
	assign new_cmd = codec_config_pkg::cmd_e'(pwdata[1:0]);

	// No wait states.
	assign pready = 1'b1;
	assign pslverr = cmd_write && status.busy;

	always_ff @(posedge CLOCK) begin
		if (RESET) begin
			cmd_valid <= 1'b0;
			cmd <= codec_config_pkg::CMD_NONE;
			frame <= '0;
		end else begin
			cmd_valid <= 1'b0;
			if (cmd_write && !status.busy && (new_cmd == codec_config_pkg::CMD_SINGLE ||
					new_cmd == codec_config_pkg::CMD_RUN_TABLE)) begin
				cmd_valid <= 1'b1;
				cmd <= new_cmd;
			end
			if (write_access && paddr == `CODEC_ADDR_FRAME) begin
				frame <= codec_config_pkg::frame_t'(pwdata[23:0]);
			end
		end
	end

	always_comb begin
		case (paddr)
		`CODEC_ADDR_CMD:    prdata = {30'd0, cmd};
		`CODEC_ADDR_FRAME:  prdata = {8'd0, frame};
		`CODEC_ADDR_STATUS: prdata = {22'd0, status};
		default:            prdata = 32'd0;
		endcase
	end

endmodule

/* logic/codec_config_ctrl.sv */
`include "codec_config_settings.svh"

module codec_config_ctrl (
	input  logic                      CLOCK,
	input  logic                      RESET,
	input  logic                      cmd_valid,
	input  codec_config_pkg::cmd_e    cmd,
	input  codec_config_pkg::frame_t  frame,
	output logic [2:0]                table_index,
	input  codec_config_pkg::frame_t  table_entry,
	output logic                      frame_go,
	output codec_config_pkg::frame_t  frame_out,
	input  logic                      frame_done,
	input  logic                      ack_error,
	output codec_config_pkg::status_t status
);

	localparam logic [2:0] LAST_INDEX = 3'(`CODEC_TABLE_LEN - 1);

	codec_config_pkg::ctrl_state_e state;
	codec_config_pkg::cmd_e        mode;
	codec_config_pkg::frame_t      single_frame;

	assign frame_out = (mode == codec_config_pkg::CMD_RUN_TABLE) ? table_entry : single_frame;

	always_ff @(posedge CLOCK) begin
		if (cmd_valid && state == codec_config_pkg::IDLE) begin
			single_frame <= frame;
		end
	end

	// Index rests at 0 while idle, so entry 0 is ready for the first send.
	always_ff @(posedge CLOCK) begin
		if (RESET) begin
			state <= codec_config_pkg::IDLE;
			mode <= codec_config_pkg::CMD_NONE;
			table_index <= 3'd0;
			frame_go <= 1'b0;
			status <= '0;
		end else begin
			frame_go <= 1'b0;
			case (state)
			codec_config_pkg::IDLE: begin
				if (cmd_valid) begin
					mode <= cmd;
					status <= '{busy: 1'b1, ack_error: 1'b0, frames_sent: 8'd0};
					frame_go <= 1'b1;
					state <= codec_config_pkg::SEND;
				end
			end
			codec_config_pkg::SEND: state <= codec_config_pkg::WAIT_FRAME;
			codec_config_pkg::WAIT_FRAME: begin
				if (frame_done) begin
					status.frames_sent <= status.frames_sent + 8'd1;
					status.ack_error <= status.ack_error | ack_error;
					if (mode == codec_config_pkg::CMD_RUN_TABLE && !ack_error &&
							table_index != LAST_INDEX) begin
						table_index <= table_index + 3'd1;
						state <= codec_config_pkg::NEXT_ENTRY;
					end else begin
						state <= codec_config_pkg::FINISH;
					end
				end
			end
			// Table output settles here.
			codec_config_pkg::NEXT_ENTRY: begin
				frame_go <= 1'b1;
				state <= codec_config_pkg::SEND;
			end
			codec_config_pkg::FINISH: begin
				status.busy <= 1'b0;
				table_index <= 3'd0;
				state <= codec_config_pkg::IDLE;
			end
			default: state <= codec_config_pkg::IDLE;
			endcase
		end
	end

	assert property (@(posedge CLOCK) disable iff (RESET)
		frame_go |-> state == codec_config_pkg::SEND);

endmodule

/* logic/codec_config_top.sv */
module codec_config_top (
	input  logic        CLOCK,
	input  logic        RESET,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [3:0]  paddr,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic        pready,
	output logic        pslverr,
	output logic        scl,
	output logic        sda_oe,
	input  logic        sda_in
);

	codec_config_pkg::status_t status;
	codec_config_pkg::cmd_e    cmd;
	codec_config_pkg::frame_t  frame;
	codec_config_pkg::frame_t  frame_out;
	codec_config_pkg::frame_t  table_entry;
	logic                      cmd_valid;
	logic [2:0]                table_index;
	logic                      frame_go;
	logic                      frame_done;
	logic                      ack_error;
	logic                      tick_enable;
	logic                      tick;

	apb_config_regs regs (
		.CLOCK, .RESET,
		.psel, .penable, .pwrite, .paddr, .pwdata,
		.prdata, .pready, .pslverr,
		.status, .cmd_valid, .cmd, .frame
	);

	codec_config_ctrl ctrl (
		.CLOCK, .RESET,
		.cmd_valid, .cmd, .frame,
		.table_index, .table_entry,
		.frame_go, .frame_out, .frame_done, .ack_error,
		.status
	);

	config_table init_table (.CLOCK, .table_index, .table_entry);

	i2c_frame_writer writer (
		.CLOCK, .RESET,
		.frame_go, .frame(frame_out),
		.tick, .tick_enable,
		.scl, .sda_oe, .sda_in,
		.frame_done, .ack_error
	);

	i2c_bit_clock bit_clock (.CLOCK, .RESET, .tick_enable, .tick);

endmodule

/* tests/codec_config_checker.sv */
module codec_config_checker (
	input logic CLOCK,
	input logic RESET,
	input logic scl,
	input logic sda
);
	timeunit 1ns;
	timeprecision 100ps;

	// Each entry holds three bytes, each followed by its ack level.
	logic [26:0] expected[$];
	logic [26:0] shift;
	int          bit_count;
	logic        prev_scl;
	logic        prev_sda;
	int          bus_errors = 0;
	int          value_errors = 0;
	int          errors_seen = 0;
	int          passed = 0;
	int          failed = 0;

	task automatic expect_frame(input logic [23:0] frame, input logic [2:0] nacks);
		expected.push_back({frame[23:16], nacks[2], frame[15:8], nacks[1], frame[7:0], nacks[0]});
	endtask

	task automatic compare(input string what, input logic [31:0] got, input logic [31:0] want);
		if (got !== want) begin
			$display("FAIL %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, want);
			value_errors++;
		end
	endtask

	task automatic check_frame();
		logic [26:0] want;
		if (bit_count != 27) begin
			$display("Stop condition at %0t after %0d bits instead of 27", $time, bit_count);
			bus_errors++;
		end else if (expected.size() == 0) begin
			$display("FAIL %0t: frame 0x%h sent while none was expected", $time, shift);
			bus_errors++;
		end else begin
			want = expected.pop_front();
			if (shift !== want) begin
				$display("FAIL %0t: bus frame 0x%h, expected 0x%h", $time, shift, want);
				bus_errors++;
			end
		end
	endtask

	// Sampled away from the clock edge where the bus lines move.
	always @(negedge CLOCK) begin
		if (RESET) begin
			prev_scl <= 1'b1;
			prev_sda <= 1'b1;
			bit_count <= 0;
		end else begin
			prev_scl <= scl;
			prev_sda <= sda;
			if (scl && prev_scl && prev_sda && !sda) begin
				bit_count <= 0;
			end else if (scl && prev_scl && !prev_sda && sda) begin
				check_frame();
			end else if (scl && !prev_scl && bit_count < 27) begin
				shift <= {shift[25:0], sda};
				bit_count <= bit_count + 1;
			end
		end
	end

	task automatic finish_test(input string name);
		int new_errors;
		if (expected.size() != 0) begin
			$display("Test %s: %0d expected frames never appeared", name, expected.size());
			value_errors++;
			expected.delete();
		end
		new_errors = bus_errors + value_errors - errors_seen;
		errors_seen = bus_errors + value_errors;
		if (new_errors == 0) begin
			passed++;
			$display("Test %s passed", name);
		end else begin
			failed++;
			$display("Test %s failed with %0d errors", name, new_errors);
		end
	endtask

	task automatic report_totals();
		$display("Tests passed: %0d, tests failed: %0d", passed, failed);
	endtask

endmodule

/* tests/codec_config_tb.sv */
`include "codec_config_settings.svh"

module codec_config_tb;
	timeunit 1ns;
	timeprecision 100ps;

	logic        CLOCK;
	logic        RESET;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [3:0]  paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;
	logic        scl;
	logic        sda_oe;
	logic        sda;
	logic        pull = 1'b0;
	logic        last_scl;
	logic        last_sda;
	int          slave_bits;
	logic [31:0] rdata;
	logic        rerr;
	logic        timed_out;
	integer      seed;
	logic        nack_plan[$];
	logic [7:0]  table_data[8] = '{8'h97, 8'h97, 8'h79, 8'h79, 8'h10, 8'h00, 8'h42, 8'h01};

	// Wired-AND of master and slave.
	assign sda = !(sda_oe || pull);

	codec_config_top uut (
		.CLOCK, .RESET, .psel, .penable, .pwrite, .paddr, .pwdata,
		.prdata, .pready, .pslverr, .scl, .sda_oe, .sda_in(sda)
	);

	codec_config_checker chk (.CLOCK, .RESET, .scl, .sda);

	initial begin
		CLOCK = 1'b0;
		forever #5 CLOCK = !CLOCK;
	end

	// Slave model. Pulls SDA low in the ninth slot unless a NACK is planned.
	always @(posedge CLOCK) begin
		#1;
		if (RESET) begin
			pull <= 1'b0;
			slave_bits <= 0;
			last_scl <= 1'b1;
			last_sda <= 1'b1;
		end else begin
			last_scl <= scl;
			last_sda <= sda;
			if (scl && last_scl && last_sda && !sda) begin
				slave_bits <= 0;
			end else if (scl && !last_scl) begin
				slave_bits <= slave_bits + 1;
			end else if (!scl && last_scl && slave_bits == 8) begin
				if (nack_plan.size() > 0) begin
					pull <= !nack_plan.pop_front();
				end else begin
					pull <= 1'b1;
				end
			end else if (!scl && last_scl && slave_bits == 9) begin
				pull <= 1'b0;
				slave_bits <= 0;
			end
		end
	end

	task automatic apb_transfer(input logic write, input logic [3:0] addr, input logic [31:0] data);
		@(posedge CLOCK);
		#1;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = write;
		paddr = addr;
		pwdata = data;
		@(posedge CLOCK);
		#1;
		penable = 1'b1;
		@(negedge CLOCK);
		rdata = prdata;
		rerr = pslverr;
		chk.compare("pready", {31'd0, pready}, 32'd1);
		@(posedge CLOCK);
		#1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic wait_idle();
		int polls;
		if (!timed_out) begin
			polls = 0;
			apb_transfer(1'b0, `CODEC_ADDR_STATUS, 32'd0);
			while (rdata[9] && polls < 5000) begin
				apb_transfer(1'b0, `CODEC_ADDR_STATUS, 32'd0);
				polls++;
			end
			if (rdata[9]) begin
				timed_out = 1'b1;
				$display("Timeout at %0t: busy did not clear after %0d status reads", $time, polls);
			end
		end
	endtask

	function automatic logic draw_nack();
		return ($random(seed) & 32'sd7) == 0;
	endfunction

	function automatic codec_config_pkg::frame_t random_frame();
		logic [31:0] r;
		r = $random(seed);
		return r[23:0];
	endfunction

	task automatic queue_frame(input codec_config_pkg::frame_t f, input logic [2:0] nacks);
		nack_plan.push_back(nacks[2]);
		nack_plan.push_back(nacks[1]);
		nack_plan.push_back(nacks[0]);
		chk.expect_frame(f, nacks);
	endtask

	task automatic start_command(input codec_config_pkg::cmd_e cmd);
		apb_transfer(1'b1, `CODEC_ADDR_CMD, {30'd0, cmd});
	endtask

	task automatic end_command(input int frames, input logic ack_error);
		wait_idle();
		if (!timed_out) begin
			chk.compare("status", rdata, {22'd0, 1'b0, ack_error, 8'(frames)});
		end
	endtask

	task automatic send_single(input codec_config_pkg::frame_t f, input logic [2:0] nacks);
		queue_frame(f, nacks);
		apb_transfer(1'b1, `CODEC_ADDR_FRAME, {8'd0, f});
		start_command(codec_config_pkg::CMD_SINGLE);
		end_command(1, |nacks);
	endtask

	// Entries go out until the first one that draws a NACK.
	task automatic run_table(input logic with_nack);
		codec_config_pkg::frame_t entry;
		logic [2:0]               nacks;
		int                       forced;
		int                       sent;
		forced = $unsigned($random(seed)) % 8;
		sent = 0;
		nacks = 3'b000;
		while (sent < 8 && nacks == 3'b000) begin
			entry = '{dev_addr: 8'h34, reg_addr: 8'(2 * sent), data: table_data[sent]};
			if (with_nack) begin
				nacks = {draw_nack(), draw_nack(), draw_nack()};
				if (sent == forced) begin
					nacks[$unsigned($random(seed)) % 3] = 1'b1;
				end
			end
			queue_frame(entry, nacks);
			sent++;
		end
		start_command(codec_config_pkg::CMD_RUN_TABLE);
		end_command(sent, |nacks);
	endtask

	initial begin
		logic [2:0]               nacks;
		codec_config_pkg::frame_t held;
		seed = 99;
		timed_out = 1'b0;
		RESET = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = 4'd0;
		pwdata = 32'd0;
		repeat (16) @(posedge CLOCK);
		#1;
		RESET = 1'b0;

		apb_transfer(1'b0, `CODEC_ADDR_STATUS, 32'd0);
		chk.compare("status after reset", rdata, 32'd0);
		chk.compare("scl after reset", {31'd0, scl}, 32'd1);
		chk.compare("sda_oe after reset", {31'd0, sda_oe}, 32'd0);
		chk.finish_test("reset state");

		repeat (3) send_single(random_frame(), 3'b000);
		chk.finish_test("single frame");

		nacks = 3'b001 << ($unsigned($random(seed)) % 3);
		send_single(random_frame(), nacks);
		send_single(random_frame(), 3'b000);
		chk.finish_test("single frame with nack");

		run_table(1'b0);
		chk.finish_test("table run");

		run_table(1'b1);
		chk.finish_test("table run with nack");

		// Command and frame writes land while the first frame is on the bus.
		held = random_frame();
		queue_frame(held, 3'b000);
		apb_transfer(1'b1, `CODEC_ADDR_FRAME, {8'd0, held});
		start_command(codec_config_pkg::CMD_SINGLE);
		held = random_frame();
		apb_transfer(1'b1, `CODEC_ADDR_FRAME, {8'd0, held});
		start_command(codec_config_pkg::CMD_RUN_TABLE);
		chk.compare("pslverr on command while busy", {31'd0, rerr}, 32'd1);
		end_command(1, 1'b0);
		queue_frame(held, 3'b000);
		start_command(codec_config_pkg::CMD_SINGLE);
		end_command(1, 1'b0);
		chk.finish_test("writes while busy");

		chk.report_totals();
		if (chk.failed == 0 && !timed_out) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

/* codec_config_top.f */
+incdir+logic
logic/codec_config_pkg.sv
logic/i2c_bit_clock.sv
logic/i2c_frame_writer.sv
logic/config_table.sv
logic/apb_config_regs.sv
logic/codec_config_ctrl.sv
logic/codec_config_top.sv
tests/codec_config_checker.sv
tests/codec_config_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/100ps --top-module codec_config_tb \
	-f codec_config_top.f -o codec_config_sim > build.log 2>&1 \
	|| { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/codec_config_sim > sim.log 2>&1 && cat sim.log \
	|| { cat sim.log; echo "Simulator exited with an error"; exit 1; }
grep -q "Simulation failed" sim.log && exit 1 || exit 0
